// File: gmii_rx.f
hdl/gmii_rx_pkg.sv
hdl/rx_byte_if.sv
hdl/gmii_input_sync.sv
hdl/rx_frame_ctrl.sv
hdl/header_capture.sv
hdl/crc32_check.sv
hdl/payload_out.sv
hdl/gmii_rx_top.sv
tb/gmii_rx_sva.sv
tb/tb_gmii_rx.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
    --top-module tb_gmii_rx -f gmii_rx.f -o sim_gmii_rx

out=$(./obj_dir/sim_gmii_rx)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: tb/tb_gmii_rx.sv
module tb_gmii_rx
    import gmii_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [47:0] LOCAL_MAC = 48'h02_1a_2b_3c_4d_5e;
    localparam logic [47:0] OTHER_MAC = 48'h02_77_66_55_44_33;
    localparam logic [47:0] SRC_MAC   = 48'h02_aa_bb_cc_dd_ee;

    typedef struct packed {
        logic [7:0]  data;
        logic        last;
        logic        fcs_ok;
        logic [47:0] src;
        logic [15:0] etype;
    } beat_t;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic [7:0]  rx_d_i;
    logic        rx_dv_i;
    logic        check_destination_i;
    logic [47:0] local_mac_i;
    logic [7:0]  m_tdata_o;
    logic        m_tvalid_o;
    logic        m_tlast_o;
    logic        fcs_ok_o;
    logic [47:0] src_mac_o;
    logic [15:0] ethertype_o;

    logic [31:0] rng_state = 32'd31;
    logic [7:0]  frame_q[$];
    logic [7:0]  payload_q[$];
    beat_t       exp_q[$];
    logic        filter_on;
    int          err_cnt = 0;
    int          err_base = 0;
    int          check_cnt = 0;
    int          beat_cnt = 0;
    int          frames_sent = 0;
    int          cycle_cnt = 0;
    // grows with every byte and idle gap that is sent
    int          budget = 200;

    gmii_rx_top i_dut (.*);

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        rng_state = xorshift32(rng_state);
        return lo + int'(rng_state % 32'(hi - lo + 1));
    endfunction

    // bit-serial Ethernet CRC, final value inverted as sent on the wire
    function automatic logic [31:0] crc32_ref(input logic [7:0] data[$]);
        logic [31:0] crc;
        logic        fb;
        crc = CRC_INIT;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = crc[0] ^ data[i][b];
                crc = crc >> 1;
                if (fb) crc = crc ^ CRC_POLY;
            end
        end
        return ~crc;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_byte(input logic [7:0] b);
        @(posedge clk_i);
        rx_d_i  <= b;
        rx_dv_i <= 1'b1;
    endtask

    task automatic build_frame(input logic [47:0] dest, input logic [47:0] src,
                               input logic [15:0] etype, input int len);
        logic [31:0] fcs;
        logic [7:0]  b;
        frame_q.delete();
        payload_q.delete();
        for (int i = 5; i >= 0; i--) frame_q.push_back(dest[8*i +: 8]);
        for (int i = 5; i >= 0; i--) frame_q.push_back(src[8*i +: 8]);
        frame_q.push_back(etype[15:8]);
        frame_q.push_back(etype[7:0]);
        for (int i = 0; i < len; i++) begin
            b = 8'(rand_range(0, 255));
            payload_q.push_back(b);
            frame_q.push_back(b);
        end
        // FCS goes out least significant byte first
        fcs = crc32_ref(frame_q);
        for (int i = 0; i < FCS_BYTES; i++) frame_q.push_back(fcs[8*i +: 8]);
    endtask

    // preamble, SFD, the first keep bytes of frame_q, then a 12 cycle gap
    task automatic send_frame(input int bad_pre, input int keep);
        budget += 8 + keep + 12;
        for (int i = 0; i < 7; i++) drive_byte((i == bad_pre) ? 8'h5d : PREAMBLE_BYTE);
        drive_byte(SFD_BYTE);
        for (int i = 0; i < keep; i++) drive_byte(frame_q[i]);
        repeat (12) begin
            @(posedge clk_i);
            rx_dv_i <= 1'b0;
            rx_d_i  <= 8'h00;
        end
    endtask

    task automatic run_frame(input logic [47:0] dest, input logic [47:0] src,
                             input logic [15:0] etype, input int len, input bit flip);
        int k;
        build_frame(dest, src, etype, len);
        // payload byte corrupted after the FCS was computed
        if (flip) begin
            k = rand_range(0, len - 1);
            payload_q[k] ^= 8'h10;
            frame_q[HEADER_BYTES + k] ^= 8'h10;
        end
        if (!filter_on || dest == LOCAL_MAC || dest == BROADCAST_MAC) begin
            foreach (payload_q[i]) begin
                exp_q.push_back(beat_t'{payload_q[i], (i == payload_q.size() - 1),
                                        !flip, src, etype});
            end
        end
        send_frame(-1, frame_q.size());
        frames_sent++;
    endtask

    task automatic set_filter(input logic en);
        @(posedge clk_i);
        check_destination_i <= en;
        filter_on = en;
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(posedge clk_i);
        $display("test %s done: %0d frames, %0d errors", name, frames_sent, err_cnt - err_base);
        frames_sent = 0;
        err_base = err_cnt;
    endtask

    always @(negedge clk_i) begin : monitor
        beat_t b;
        if (!rst_i && m_tvalid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("unexpected output byte %02h at %0t, no frame was pending",
                         m_tdata_o, $time);
            end else begin
                b = exp_q.pop_front();
                beat_cnt++;
                check_value(64'(m_tdata_o), 64'(b.data), "m_tdata_o");
                check_value(64'(m_tlast_o), 64'(b.last), "m_tlast_o");
                if (b.last) begin
                    check_value(64'(fcs_ok_o), 64'(b.fcs_ok), "fcs_ok_o");
                    check_value(64'(src_mac_o), 64'(b.src), "src_mac_o");
                    check_value(64'(ethertype_o), 64'(b.etype), "ethertype_o");
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > budget) begin
            $display("timeout after %0d cycles, %0d expected output bytes never arrived",
                     cycle_cnt, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst_i               <= 1'b1;
        rx_d_i              <= 8'h00;
        rx_dv_i             <= 1'b0;
        check_destination_i <= 1'b1;
        local_mac_i         <= LOCAL_MAC;
        filter_on = 1'b1;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int n = 0; n < 12; n++) run_frame(LOCAL_MAC, SRC_MAC, 16'h0800, rand_range(1, 60), 0);
        end_test("local unicast");

        // other unicast dropped while filtering, broadcast passes either way
        for (int n = 0; n < 3; n++) run_frame(OTHER_MAC, SRC_MAC, 16'h0800, rand_range(1, 60), 0);
        set_filter(1'b0);
        for (int n = 0; n < 3; n++) run_frame(OTHER_MAC, SRC_MAC, 16'h0800, rand_range(1, 60), 0);
        run_frame(BROADCAST_MAC, SRC_MAC, 16'h0806, rand_range(1, 60), 0);
        set_filter(1'b1);
        run_frame(BROADCAST_MAC, SRC_MAC, 16'h0806, rand_range(1, 60), 0);
        end_test("address filter");

        for (int n = 0; n < 4; n++) run_frame(LOCAL_MAC, SRC_MAC, 16'h0800, rand_range(1, 60), 1);
        end_test("bad fcs");

        for (int n = 0; n < 6; n++) begin
            run_frame(LOCAL_MAC, {16'(rand_range(0, 65535)), 16'(rand_range(0, 65535)),
                      16'(rand_range(0, 65535))}, 16'(rand_range(0, 65535)),
                      rand_range(1, 60), 0);
        end
        end_test("header fields");

        // runts cut inside the header or before a payload byte follows the FCS
        for (int n = 0; n < 3; n++) begin
            build_frame(LOCAL_MAC, SRC_MAC, 16'h0800, rand_range(1, 60));
            send_frame(rand_range(0, 6), frame_q.size());
            build_frame(LOCAL_MAC, SRC_MAC, 16'h0800, rand_range(1, 60));
            send_frame(-1, rand_range(1, HEADER_BYTES + FCS_BYTES));
            frames_sent += 2;
            run_frame(LOCAL_MAC, SRC_MAC, 16'h0800, rand_range(1, 60), 0);
        end
        end_test("bad preamble and runt");

        $display("%0d output bytes, %0d checks, %0d errors", beat_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/gmii_rx_sva.sv
module gmii_rx_sva
    import gmii_rx_pkg::*;
(
    input logic      clk_i,
    input logic      rst_i,
    input logic      m_tvalid_o,
    input logic      m_tlast_o,
    input rx_state_e state_i,
    input logic      eof_i
);

    timeunit 1ns;
    timeprecision 100ps;

    tlast_with_valid: assert property (
        @(posedge clk_i) disable iff (rst_i) m_tlast_o |-> m_tvalid_o
    ) else $error("m_tlast_o high without m_tvalid_o");

    quiet_after_reset: assert property (
        @(posedge clk_i) rst_i |=> !m_tvalid_o
    ) else $error("m_tvalid_o high in the cycle after reset");

    // only the closing beat may appear once the controller has left PAYLOAD
    beat_inside_frame: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (m_tvalid_o && (state_i == IDLE || state_i == DISCARD)) |-> (m_tlast_o && $past(eof_i))
    ) else $error("output beat while the controller is idle or discarding");

endmodule

bind gmii_rx_top gmii_rx_sva i_sva (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .m_tvalid_o (m_tvalid_o),
    .m_tlast_o  (m_tlast_o),
    .state_i    (i_ctrl.state_q),
    .eof_i      (i_sync.eof_q)
);

// File: hdl/gmii_rx_top.sv
module gmii_rx_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,
    input  logic        check_destination_i,
    input  logic [47:0] local_mac_i,
    output logic [7:0]  m_tdata_o,
    output logic        m_tvalid_o,
    output logic        m_tlast_o,
    output logic        fcs_ok_o,
    output logic [47:0] src_mac_o,
    output logic [15:0] ethertype_o
);

    rx_byte_if rx_bus ();

    logic hdr_shift;
    logic crc_clear;
    logic crc_en;
    logic pay_en;
    logic frame_end;
    logic dest_match;
    logic crc_ok;

    gmii_input_sync i_sync (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rx_d_i  (rx_d_i),
        .rx_dv_i (rx_dv_i),
        .rx_o    (rx_bus.source)
    );

    rx_frame_ctrl i_ctrl (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .rx_i                (rx_bus.sink),
        .check_destination_i (check_destination_i),
        .dest_match_i        (dest_match),
        .hdr_shift_o         (hdr_shift),
        .crc_clear_o         (crc_clear),
        .crc_en_o            (crc_en),
        .pay_en_o            (pay_en),
        .frame_end_o         (frame_end)
    );

    header_capture i_hdr (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rx_i         (rx_bus.sink),
        .hdr_shift_i  (hdr_shift),
        .local_mac_i  (local_mac_i),
        .dest_match_o (dest_match),
        .src_mac_o    (src_mac_o),
        .ethertype_o  (ethertype_o)
    );

    crc32_check i_crc (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rx_i        (rx_bus.sink),
        .crc_clear_i (crc_clear),
        .crc_en_i    (crc_en),
        .fcs_ok_o    (crc_ok)
    );

    payload_out i_pay (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rx_i        (rx_bus.sink),
        .pay_en_i    (pay_en),
        .frame_end_i (frame_end),
        .fcs_ok_i    (crc_ok),
        .m_tdata_o   (m_tdata_o),
        .m_tvalid_o  (m_tvalid_o),
        .m_tlast_o   (m_tlast_o),
        .fcs_ok_o    (fcs_ok_o)
    );

endmodule

// File: hdl/payload_out.sv
module payload_out
    import gmii_rx_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    rx_byte_if.sink    rx_i,
    input  logic       pay_en_i,
    input  logic       frame_end_i,
    input  logic       fcs_ok_i,
    output logic [7:0] m_tdata_o,
    output logic       m_tvalid_o,
    output logic       m_tlast_o,
    output logic       fcs_ok_o
);

    // four byte delay line, slot 0 newest
    logic [FCS_BYTES-1:0][7:0] dly_q;
    logic [2:0]                fill_q;
    logic                      full;

    // byte that left the delay line and waits to learn if it is the last one
    logic [7:0] pend_q;
    logic       pend_vld_q;

    assign full = (fill_q == 3'(FCS_BYTES));

    always_ff @(posedge clk_i) begin
        if (pay_en_i) begin
            dly_q <= {dly_q[FCS_BYTES-2:0], rx_i.data};
            if (full) begin
                pend_q <= dly_q[FCS_BYTES-1];
            end
        end
        if ((pay_en_i && pend_vld_q) || frame_end_i) begin
            m_tdata_o <= pend_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fill_q     <= '0;
            pend_vld_q <= 1'b0;
            m_tvalid_o <= 1'b0;
            m_tlast_o  <= 1'b0;
            fcs_ok_o   <= 1'b0;
        end else begin
            m_tvalid_o <= 1'b0;
            m_tlast_o  <= 1'b0;
            fcs_ok_o   <= 1'b0;
            if (pay_en_i) begin
                if (!full) begin
                    fill_q <= fill_q + 3'd1;
                end else begin
                    pend_vld_q <= 1'b1;
                end
                m_tvalid_o <= pend_vld_q;
            end
            if (frame_end_i) begin
                m_tvalid_o <= 1'b1;
                m_tlast_o  <= 1'b1;
                fcs_ok_o   <= fcs_ok_i;
            end
            // held bytes are the FCS or a runt, drop them
            if (rx_i.eof) begin
                fill_q     <= '0;
                pend_vld_q <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/crc32_check.sv
module crc32_check
    import gmii_rx_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    rx_byte_if.sink rx_i,
    input  logic    crc_clear_i,
    input  logic    crc_en_i,
    output logic    fcs_ok_o
);

    logic [31:0] crc_q;

    // one byte through the reflected polynomial, lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            crc_q <= CRC_INIT;
        end else if (crc_clear_i) begin
            crc_q <= CRC_INIT;
        end else if (crc_en_i) begin
            crc_q <= crc_step(crc_q, rx_i.data);
        end
    end

    // no final inversion, the FCS folds the register to a fixed residue
    assign fcs_ok_o = (crc_q == CRC_RESIDUE);

endmodule

// File: hdl/header_capture.sv
module header_capture
    import gmii_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    rx_byte_if.sink     rx_i,
    input  logic        hdr_shift_i,
    input  logic [47:0] local_mac_i,
    output logic        dest_match_o,
    output logic [47:0] src_mac_o,
    output logic [15:0] ethertype_o
);

    // byte 0 of the header ends up in hdr_q[0] after the last shift
    logic [HEADER_BYTES-1:0][7:0] hdr_q;
    logic [HEADER_BYTES-1:0][7:0] hdr_next;
    logic [47:0]                  dest_mac;

    assign hdr_next = {rx_i.data, hdr_q[HEADER_BYTES-1:1]};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hdr_q <= '0;
        end else if (hdr_shift_i) begin
            hdr_q <= hdr_next;
        end
    end

    // taken from the view with the current byte already shifted in,
    // so the match is valid while the last header byte is on the bus
    assign dest_mac = {<<8{hdr_next[5:0]}};

    assign dest_match_o = (dest_mac == local_mac_i) || (dest_mac == BROADCAST_MAC);

    // wire order is most significant byte first
    assign src_mac_o   = {<<8{hdr_q[11:6]}};
    assign ethertype_o = {hdr_q[12], hdr_q[13]};

endmodule

// File: hdl/rx_frame_ctrl.sv
module rx_frame_ctrl
    import gmii_rx_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    rx_byte_if.sink rx_i,
    input  logic    check_destination_i,
    input  logic    dest_match_i,
    output logic    hdr_shift_o,
    output logic    crc_clear_o,
    output logic    crc_en_o,
    output logic    pay_en_o,
    output logic    frame_end_o
);

    rx_state_e  state_q;
    rx_state_e  state_d;
    logic [3:0] cnt_q;
    logic       accept;
    logic       hdr_last;
    logic       len_ok;

    assign accept   = !check_destination_i || dest_match_i;
    assign hdr_last = (cnt_q == 4'(HEADER_BYTES - 1));

    // payload count saturates once the frame is long enough to carry data
    assign len_ok = (cnt_q > 4'(FCS_BYTES));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (rx_i.sof) begin
                    state_d = (rx_i.data == PREAMBLE_BYTE) ? PREAMBLE : DISCARD;
                end
            end
            PREAMBLE: begin
                if (rx_i.byte_vld) begin
                    if (rx_i.data == SFD_BYTE) begin
                        state_d = HEADER;
                    end else if (rx_i.data != PREAMBLE_BYTE) begin
                        state_d = DISCARD;
                    end
                end
            end
            HEADER: begin
                // destination filter is decided on the last header byte
                if (rx_i.byte_vld && hdr_last) begin
                    state_d = accept ? PAYLOAD : DISCARD;
                end
            end
            default: begin
                state_d = state_q;
            end
        endcase
        if (rx_i.eof) begin
            state_d = IDLE;
        end
    end

    assign hdr_shift_o = (state_q == HEADER) && rx_i.byte_vld;
    assign pay_en_o    = (state_q == PAYLOAD) && rx_i.byte_vld;
    assign crc_en_o    = hdr_shift_o || pay_en_o;
    assign crc_clear_o = (state_q == PREAMBLE) && rx_i.byte_vld && (rx_i.data == SFD_BYTE);
    assign frame_end_o = (state_q == PAYLOAD) && rx_i.eof && len_ok;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // header byte count, then payload byte count
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (state_q != state_d) begin
            cnt_q <= '0;
        end else if (hdr_shift_o || (pay_en_o && !len_ok)) begin
            cnt_q <= cnt_q + 4'd1;
        end
    end

endmodule

// File: hdl/gmii_input_sync.sv
module gmii_input_sync (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic [7:0] rx_d_i,
    input  logic       rx_dv_i,
    rx_byte_if.source  rx_o
);

    logic [7:0] data_q;
    logic       vld_q;
    logic       sof_q;
    logic       eof_q;

    always_ff @(posedge clk_i) begin
        data_q <= rx_d_i;
    end

    // vld_q doubles as the previous data-valid for the edge detect
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= 1'b0;
            sof_q <= 1'b0;
            eof_q <= 1'b0;
        end else begin
            vld_q <= rx_dv_i;
            sof_q <= rx_dv_i && !vld_q;
            eof_q <= !rx_dv_i && vld_q;
        end
    end

    assign rx_o.data     = data_q;
    assign rx_o.byte_vld = vld_q;
    assign rx_o.sof      = sof_q;
    assign rx_o.eof      = eof_q;

endmodule

// File: hdl/rx_byte_if.sv
interface rx_byte_if;

    // registered GMII byte
    logic [7:0] data;
    logic       byte_vld;

    // frame edges, each one cycle wide
    logic sof;
    logic eof;

    modport source (
        output data,
        output byte_vld,
        output sof,
        output eof
    );

    modport sink (
        input data,
        input byte_vld,
        input sof,
        input eof
    );

endinterface

// File: hdl/gmii_rx_pkg.sv
package gmii_rx_pkg;

    // preamble and start-of-frame delimiter as seen on the GMII byte lane
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;

    // destination, source and EtherType
    localparam int HEADER_BYTES = 14;
    localparam int FCS_BYTES    = 4;

    // reflected CRC-32 as used by IEEE 802.3
    localparam logic [31:0] CRC_POLY = 32'hedb88320;
    localparam logic [31:0] CRC_INIT = 32'hffffffff;

    // register value after a good frame has been run through including its FCS
    localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

    localparam logic [47:0] BROADCAST_MAC = 48'hffff_ffff_ffff;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        HEADER,
        PAYLOAD,
        DISCARD
    } rx_state_e;

endpackage
